/* hw/dm_cfg.svh */
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// Wishbone geometry
`define DM_ADR_W 2
`define DM_DAT_W 32

// Register word addresses
`define DM_ADR_CTRL 2'd0
`define DM_ADR_DIV 2'd1

// One row per ms at 50 MHz
`define DM_DIV_RESET 16'd50000

`endif

/* hw/dm_pkg.sv */
`default_nettype none

package dm_pkg;

    typedef logic [2:0] dm_glyph_t;     // 0..5 digits, 6 question mark, 7 heart
    typedef logic [7:0] dm_cols_t;      // One color, one row

    // Control word at address 0
    typedef struct packed {
        logic [24:0] rsvd_hi;
        dm_glyph_t   glyph;             // Bits 6..4
        logic [2:0]  rsvd_lo;
        logic        enable;            // Bit 0
    } dm_ctrl_t;

    // Divisor word at address 1
    typedef struct packed {
        logic [15:0] rsvd;
        logic [15:0] count;             // Clocks per row
    } dm_div_t;

    typedef union packed {
        dm_ctrl_t ctrl;
        dm_div_t  div;
    } dm_reg_word_u;

endpackage

`default_nettype wire

/* hw/dm_wb_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dm_cfg.svh"

module dm_wb_regs (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cyc,
    input  wire logic                 stb,
    input  wire logic                 we,
    input  wire logic [`DM_ADR_W-1:0] adr,
    input  wire logic [`DM_DAT_W-1:0] dat_w,
    output logic      [`DM_DAT_W-1:0] dat_r,
    output logic                      ack,
    output logic                      enable,
    output dm_pkg::dm_glyph_t         glyph,
    output logic      [15:0]          div_count
);
    import dm_pkg::*;

    logic         access;
    dm_reg_word_u wr_word;
    dm_reg_word_u rd_word;

    assign access  = cyc && stb && !ack;    // First clock of a valid cycle
    assign wr_word = dat_w;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ack <= 1'b0;
        else
            ack <= access;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            enable    <= 1'b0;
            glyph     <= '0;
            div_count <= `DM_DIV_RESET;
        end
        else if (access && we)
        begin
            if (adr == `DM_ADR_CTRL)
            begin
                enable <= wr_word.ctrl.enable;
                glyph  <= wr_word.ctrl.glyph;
            end
            else if (adr == `DM_ADR_DIV)
            begin
                if (wr_word.div.count == 16'd0)
                    div_count <= 16'd1;         // Zero would stall the scan
                else
                    div_count <= wr_word.div.count;
            end
        end
    end

    always_comb
    begin
        rd_word = '0;                           // Reserved and unmapped read zero
        if (adr == `DM_ADR_CTRL)
        begin
            rd_word.ctrl.enable = enable;
            rd_word.ctrl.glyph  = glyph;
        end
        else if (adr == `DM_ADR_DIV)
            rd_word.div.count = div_count;
    end

    always_ff @(posedge clk)
    begin
        if (access && !we)
            dat_r <= rd_word;
    end

endmodule

`default_nettype wire

/* hw/dm_scan_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module dm_scan_timer (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        enable,
    input  wire logic [15:0] div_count,
    output logic             row_tick
);

    logic [15:0] cnt;
    logic [15:0] rem;

    assign rem = (cnt == 16'd0) ? div_count : cnt;  // Zero means start of period

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt      <= 16'd0;
            row_tick <= 1'b0;
        end
        else if (!enable)
        begin
            cnt      <= 16'd0;
            row_tick <= 1'b0;
        end
        else if (rem == 16'd1)
        begin
            cnt      <= 16'd0;                      // Reload on next clock
            row_tick <= 1'b1;
        end
        else
        begin
            cnt      <= rem - 16'd1;
            row_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/dm_glyph_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module dm_glyph_rom (
    input  wire dm_pkg::dm_glyph_t glyph,
    input  wire logic [2:0]        row_idx,
    output dm_pkg::dm_cols_t       red,
    output dm_pkg::dm_cols_t       green
);
    import dm_pkg::*;

    // Row 0 first, bit 7 is the leftmost column
    localparam dm_cols_t FONT [64] = '{
        8'b0000_0000,   // Digit 0
        8'b0011_1100,
        8'b0110_0110,
        8'b0110_1110,
        8'b0111_0110,
        8'b0110_0110,
        8'b0110_0110,
        8'b0011_1100,
        8'b0000_0000,   // Digit 1
        8'b0001_1000,
        8'b0011_1000,
        8'b0001_1000,
        8'b0001_1000,
        8'b0001_1000,
        8'b0001_1000,
        8'b0111_1110,
        8'b0000_0000,   // Digit 2
        8'b0011_1100,
        8'b0110_0110,
        8'b0000_0110,
        8'b0000_1100,
        8'b0011_0000,
        8'b0110_0000,
        8'b0111_1110,
        8'b0000_0000,   // Digit 3
        8'b0011_1100,
        8'b0110_0110,
        8'b0000_0110,
        8'b0001_1100,
        8'b0000_0110,
        8'b0110_0110,
        8'b0011_1100,
        8'b0000_0000,   // Digit 4
        8'b0000_1100,
        8'b0001_1100,
        8'b0010_1100,
        8'b0100_1100,
        8'b0111_1110,
        8'b0000_1100,
        8'b0000_1100,
        8'b0000_0000,   // Digit 5
        8'b0111_1110,
        8'b0110_0000,
        8'b0111_1100,
        8'b0000_0110,
        8'b0000_0110,
        8'b0110_0110,
        8'b0011_1100,
        8'b0011_1100,   // Question mark
        8'b0110_0110,
        8'b0000_0110,
        8'b0000_1100,
        8'b0001_1000,
        8'b0001_1000,
        8'b0000_0000,
        8'b0001_1000,
        8'b0000_0000,   // Heart
        8'b0110_0110,
        8'b1111_1111,
        8'b1111_1111,
        8'b0111_1110,
        8'b0011_1100,
        8'b0001_1000,
        8'b0000_0000
    };

    dm_cols_t pix;
    logic     use_red;
    logic     use_green;

    assign pix = FONT[{glyph, row_idx}];

    always_comb
    begin
        case (glyph)
            3'd0, 3'd1:
            begin
                use_red   = 1'b0;               // Green
                use_green = 1'b1;
            end
            3'd4, 3'd5, 3'd6:
            begin
                use_red   = 1'b1;               // Red
                use_green = 1'b0;
            end
            default:
            begin
                use_red   = 1'b1;               // Yellow for 2, 3 and 7
                use_green = 1'b1;
            end
        endcase
    end

    assign red   = use_red ? pix : '0;
    assign green = use_green ? pix : '0;

endmodule

`default_nettype wire

/* hw/dm_row_scanner.sv */
`timescale 1ns/1ns
`default_nettype none

module dm_row_scanner (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              enable,
    input  wire dm_pkg::dm_glyph_t glyph,
    input  wire logic              row_tick,
    output dm_pkg::dm_glyph_t      rom_glyph,
    output logic [2:0]             rom_row,
    input  wire dm_pkg::dm_cols_t  rom_red,
    input  wire dm_pkg::dm_cols_t  rom_green,
    output logic [7:0]             row,
    output dm_pkg::dm_cols_t       colr,
    output dm_pkg::dm_cols_t       colg
);
    import dm_pkg::*;

    logic [2:0] row_idx;
    dm_glyph_t  glyph_q;                            // Glyph of the current frame

    // ROM looks one row ahead so its columns land with the row select
    assign rom_row   = row_idx + 3'd1;
    assign rom_glyph = (rom_row == 3'd0) ? glyph : glyph_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= 3'd7;
            glyph_q <= '0;
            row     <= 8'hFF;
            colr    <= '0;
            colg    <= '0;
        end
        else if (!enable)
        begin
            row_idx <= 3'd7;                        // Next step lands on row 0
            row     <= 8'hFF;
            colr    <= '0;
            colg    <= '0;
        end
        else if (row_tick)
        begin
            row_idx <= rom_row;
            glyph_q <= rom_glyph;                   // Only differs at frame start
            row     <= ~(8'b0000_0001 << rom_row);
            colr    <= rom_red;
            colg    <= rom_green;
        end
    end

endmodule

`default_nettype wire

/* hw/dm_display_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dm_cfg.svh"

module dm_display_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cyc,
    input  wire logic                 stb,
    input  wire logic                 we,
    input  wire logic [`DM_ADR_W-1:0] adr,
    input  wire logic [`DM_DAT_W-1:0] dat_w,
    output wire logic [`DM_DAT_W-1:0] dat_r,
    output wire logic                 ack,
    output wire logic [7:0]           row,
    output wire dm_pkg::dm_cols_t     colr,
    output wire dm_pkg::dm_cols_t     colg
);
    import dm_pkg::*;

    wire            enable;
    wire dm_glyph_t glyph;
    wire [15:0]     div_count;
    wire            row_tick;
    wire dm_glyph_t rom_glyph;
    wire [2:0]      rom_row;
    wire dm_cols_t  rom_red;
    wire dm_cols_t  rom_green;

    dm_wb_regs regs0 (
        .clk(clk), .rst(rst),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .enable(enable), .glyph(glyph), .div_count(div_count)
    );

    dm_scan_timer timer0 (
        .clk(clk), .rst(rst), .enable(enable),
        .div_count(div_count), .row_tick(row_tick)
    );

    dm_row_scanner scanner0 (
        .clk(clk), .rst(rst), .enable(enable),
        .glyph(glyph), .row_tick(row_tick),
        .rom_glyph(rom_glyph), .rom_row(rom_row),
        .rom_red(rom_red), .rom_green(rom_green),
        .row(row), .colr(colr), .colg(colg)
    );

    dm_glyph_rom rom0 (
        .glyph(rom_glyph), .row_idx(rom_row),
        .red(rom_red), .green(rom_green)
    );

endmodule

`default_nettype wire

/* testbench/dm_display_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module dm_display_sva (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       ack,
    input wire logic       enable,
    input wire logic [7:0] row
);

    int fail_count = 0;     // Read by the testbench at the end

    // Single-clock ack
    ack_one_cycle_a: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else
    begin
        $error("ack stayed high for more than one clock");
        fail_count++;
    end

    // Disabled display is blank from the next clock on
    blank_when_off_a: assert property (@(posedge clk) disable iff (rst)
        !enable |=> (row == 8'hFF))
    else
    begin
        $error("row select active while the display is disabled");
        fail_count++;
    end

    // Before the first tick the row is still blank
    one_row_when_on_a: assert property (@(posedge clk) disable iff (rst)
        enable |-> (row == 8'hFF || $onehot(~row)))
    else
    begin
        $error("more than one row selected");
        fail_count++;
    end

endmodule

bind dm_display_top dm_display_sva sva0 (
    .clk(clk), .rst(rst), .ack(ack), .enable(enable), .row(row)
);

`default_nettype wire

/* testbench/dm_display_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dm_cfg.svh"

module dm_display_tb;
    import dm_pkg::*;

    // Frames x 8 x divisor per test, plus bus cycles and reset, doubled
    localparam int CYCLE_LIMIT = 2 * (3*8*4 + 3*8*5 + 8*3*8*3 + 3*8*20
                                      + 24*(15*8 + 8) + 2*8*8 + 400 + 8);

    logic                 clk = 1'b0;
    logic                 rst, cyc, stb, we;
    logic [`DM_ADR_W-1:0] adr;
    logic [`DM_DAT_W-1:0] dat_w;
    wire  [`DM_DAT_W-1:0] dat_r;
    wire                  ack;
    wire  [7:0]           row;
    dm_cols_t             colr, colg;

    string     test_name = "reset";
    int        n_checks = 0, n_errors = 0, checks0, errors0, cycles = 0;
    integer    seed;
    dm_glyph_t sh_glyph = '0;                   // Mirror of the glyph register
    logic [7:0] last_row;
    logic [2:0] exp_idx, cur_idx;
    dm_glyph_t  frame_glyph, glyph_prev;
    int         gap, last_gap, steps = 0, frame_cnt = 0;

    dm_display_top dut0 (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .row(row), .colr(colr), .colg(colg)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycles++;

    // Expected red and green columns, red in the upper byte
    function automatic logic [15:0] ref_cols(input dm_glyph_t g, input logic [2:0] r);
        logic [63:0] bits;
        logic [7:0]  line;
        int          sh;
        begin
            case (g)
                3'd0: bits = 64'h003C_666E_7666_663C;
                3'd1: bits = 64'h0018_3818_1818_187E;
                3'd2: bits = 64'h003C_6606_0C30_607E;
                3'd3: bits = 64'h003C_6606_1C06_663C;
                3'd4: bits = 64'h000C_1C2C_4C7E_0C0C;
                3'd5: bits = 64'h007E_607C_0606_663C;
                3'd6: bits = 64'h3C66_060C_1818_0018;
                default: bits = 64'h0066_FFFF_7E3C_1800;
            endcase
            sh = 56 - 8 * int'(r);              // Row 0 in the top byte
            line = bits[sh +: 8];
            ref_cols[15:8] = (g >= 3'd2) ? line : 8'h00;
            ref_cols[7:0]  = (g <= 3'd3 || g == 3'd7) ? line : 8'h00;
        end
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_cols(input string what, input dm_cols_t exp, input dm_cols_t act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_row(input string what, input logic [7:0] exp, input logic [7:0] act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic wb_write(input logic [`DM_ADR_W-1:0] a, input logic [31:0] d);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        adr = a;
        dat_w = d;
        @(posedge clk);
        #1;
        while (!ack)
        begin
            @(posedge clk);
            #1;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        if (a == `DM_ADR_CTRL)
            sh_glyph = d[6:4];
    endtask

    task automatic wb_read(input logic [`DM_ADR_W-1:0] a, output logic [31:0] d);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b0;
        adr = a;
        @(posedge clk);
        #1;
        while (!ack)
        begin
            @(posedge clk);
            #1;
        end
        d = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic ctrl_write(input logic en, input dm_glyph_t g);
        wb_write(`DM_ADR_CTRL, {25'd0, g, 3'd0, en});
    endtask

    task automatic wait_steps(input int n);
        int target;
        target = steps + n;
        while (steps < target)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_index(input logic [2:0] idx);
        while (cur_idx != idx)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        checks0   = n_checks;
        errors0   = n_errors;
    endtask

    task automatic end_test;
        $display("%s: %0d checks, %0d errors", test_name, n_checks - checks0, n_errors - errors0);
    endtask

    // Row monitor, sampled on the falling edge
    always @(negedge clk)
    begin
        logic [15:0] exp_cols;
        if (rst)
        begin
            last_row = 8'hFF;
            exp_idx = 3'd0;
            cur_idx = 3'd7;
            frame_glyph = '0;
            glyph_prev = '0;
            gap = 0;
            last_gap = 0;
        end
        else
        begin
            if (row != last_row)
            begin
                if (row == 8'hFF)
                begin
                    check_cols("blank red", 8'h00, colr);
                    check_cols("blank green", 8'h00, colg);
                    exp_idx = 3'd0;             // Scan restarts at row 0
                    cur_idx = 3'd7;
                end
                else
                begin
                    if ($countones(row) != 7)
                    begin
                        n_errors++;
                        $display("%s: row select %b does not have exactly one low bit",
                                 test_name, row);
                    end
                    check_row("row order", ~(8'h01 << exp_idx), row);
                    if (exp_idx == 3'd0)
                    begin
                        frame_glyph = glyph_prev;
                        frame_cnt++;
                    end
                    exp_cols = ref_cols(frame_glyph, exp_idx);
                    check_cols("red columns", exp_cols[15:8], colr);
                    check_cols("green columns", exp_cols[7:0], colg);
                    last_gap = gap;
                    gap      = 0;
                    cur_idx  = exp_idx;
                    exp_idx  = exp_idx + 3'd1;
                    steps++;
                end
                last_row = row;
            end
            gap++;
            glyph_prev = sh_glyph;              // Register value before the next edge
        end
    end

    initial
    begin : watchdog
        while (cycles < CYCLE_LIMIT)
            @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial
    begin
        logic [31:0] rd;
        logic [15:0] d;
        logic [15:0] exp_c;
        dm_glyph_t   g;
        int          k;
        seed = 32'h53b5_6c47;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("registers");
        wb_read(`DM_ADR_CTRL, rd);
        check_word("control after reset", 32'd0, rd);
        wb_read(`DM_ADR_DIV, rd);
        check_word("divisor after reset", {16'd0, 16'd50000}, rd);
        wb_write(`DM_ADR_CTRL, 32'hFFFF_FFDE);  // Glyph 5, enable low
        wb_read(`DM_ADR_CTRL, rd);
        check_word("control readback", {25'd0, 3'd5, 3'd0, 1'b0}, rd);
        wb_write(`DM_ADR_DIV, 32'hABCD_0007);
        wb_read(`DM_ADR_DIV, rd);
        check_word("divisor readback", 32'd7, rd);
        wb_write(`DM_ADR_DIV, 32'd0);
        wb_read(`DM_ADR_DIV, rd);
        check_word("zero divisor", 32'd1, rd);
        wb_write(2'd2, 32'hFFFF_FFFF);
        wb_write(2'd3, 32'hFFFF_FFFF);
        wb_read(2'd2, rd);
        check_word("address 2", 32'd0, rd);
        wb_read(2'd3, rd);
        check_word("address 3", 32'd0, rd);
        wb_read(`DM_ADR_CTRL, rd);
        check_word("control unchanged", {25'd0, 3'd5, 3'd0, 1'b0}, rd);
        end_test;

        start_test("blanking");
        check_row("row while off", 8'hFF, row);
        check_cols("red while off", 8'h00, colr);
        check_cols("green while off", 8'h00, colg);
        wb_write(`DM_ADR_DIV, 32'd4);
        ctrl_write(1'b1, 3'd2);
        wait_steps(10);
        ctrl_write(1'b0, 3'd2);
        repeat (2) @(posedge clk);
        #1;
        check_row("row after disable", 8'hFF, row);
        check_cols("red after disable", 8'h00, colr);
        check_cols("green after disable", 8'h00, colg);
        ctrl_write(1'b1, 3'd2);
        wait_steps(1);
        check_row("first row after enable", 8'hFE, row);
        wait_steps(8);
        end_test;

        start_test("scan rate");
        wb_write(`DM_ADR_DIV, 32'd5);
        wait_steps(2);
        repeat (16)
        begin
            wait_steps(1);
            check_word("row period", 32'd5, last_gap);
        end
        end_test;

        start_test("glyphs");
        wb_write(`DM_ADR_DIV, 32'd3);
        for (int i = 0; i < 8; i++)
        begin
            ctrl_write(1'b1, 3'(i));
            wait_frames(2);
        end
        end_test;

        start_test("frame sync");
        wb_write(`DM_ADR_DIV, 32'd20);
        ctrl_write(1'b1, 3'd3);
        wait_frames(2);
        wait_index(3'd3);
        ctrl_write(1'b1, 3'd6);                 // Mid-frame change
        wait_index(3'd7);
        exp_c = ref_cols(3'd3, 3'd7);
        check_cols("old red on row 7", exp_c[15:8], colr);
        check_cols("old green on row 7", exp_c[7:0], colg);
        wait_frames(1);
        exp_c = ref_cols(3'd6, 3'd0);
        check_cols("new red on row 0", exp_c[15:8], colr);
        check_cols("new green on row 0", exp_c[7:0], colg);
        end_test;

        start_test("random");
        for (int i = 0; i < 24; i++)
        begin
            d = 16'($unsigned($random(seed)) % 8) + 16'd1;
            g = 3'($unsigned($random(seed)) % 8);
            k = int'($unsigned($random(seed)) % 16);
            wb_write(`DM_ADR_DIV, {16'd0, d});
            ctrl_write(1'b1, g);
            wait_steps(k);
        end
        wait_frames(2);
        end_test;

        if (dut0.sva0.fail_count != 0)
        begin
            n_errors++;
            $display("%0d assertion failures were reported", dut0.sva0.fail_count);
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
hw/dm_pkg.sv
hw/dm_wb_regs.sv
hw/dm_scan_timer.sv
hw/dm_glyph_rom.sv
hw/dm_row_scanner.sv
hw/dm_display_top.sv
testbench/dm_display_sva.sv
testbench/dm_display_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dm_display_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
